/* hdl/lsu_pkg.sv */
/* shared widths, opcodes and bundles of the load/store unit
   sv39 only: the overflow check assumes a 39-bit virtual address */
package lsu_pkg;

    localparam int unsigned XLEN          = 64;
    localparam int unsigned VLEN          = 39;
    localparam int unsigned SV            = 39;
    localparam int unsigned TRANS_ID_BITS = 3;

    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // functional unit select
    typedef enum logic [1:0] {
        FU_NONE,
        FU_LOAD,
        FU_STORE
    } fu_t;

    // integer loads and stores only
    typedef enum logic [3:0] {
        LB, LBU, LH, LHU, LW, LWU, LD,
        SB, SH, SW, SD
    } lsu_op_t;

    // riscv mcause codes
    typedef enum logic [XLEN-1:0] {
        LD_ADDR_MISALIGNED = 64'd4,
        LD_ACCESS_FAULT    = 64'd5,
        ST_ADDR_MISALIGNED = 64'd6,
        ST_ACCESS_FAULT    = 64'd7
    } exc_cause_t;

    typedef struct packed {
        exc_cause_t      cause;
        logic [XLEN-1:0] tval;
        logic            valid;
    } exception_t;

    // issue bundle, operand_b is the store data
    typedef struct packed {
        fu_t             fu;
        lsu_op_t         op;
        logic [XLEN-1:0] operand_a;
        logic [XLEN-1:0] operand_b;
        logic [XLEN-1:0] imm;
        trans_id_t       trans_id;
    } fu_data_t;

    typedef struct packed {
        logic            valid;
        logic [VLEN-1:0] vaddr;
        logic            overflow;
        logic [XLEN-1:0] data;
        logic [7:0]      be;
        fu_t             fu;
        lsu_op_t         op;
        trans_id_t       trans_id;
    } lsu_req_t;

    typedef struct packed {
        logic            valid;
        trans_id_t       trans_id;
        logic [XLEN-1:0] result;
        exception_t      ex;
    } lsu_result_t;

    // log2 of the transfer size in bytes
    function automatic logic [1:0] op_size(lsu_op_t op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            LW, LWU, SW: return 2'd2;
            default:     return 2'd3;
        endcase
    endfunction

endpackage

/* hdl/result_pipe.sv */
/* Depth-stage delay of a result stream, Depth 0 is a plain wire
   only the valid bits are reset */
module result_pipe #(
    parameter int unsigned Depth = 1
)(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  lsu_pkg::lsu_result_t d_i,
    output lsu_pkg::lsu_result_t d_o
);
    import lsu_pkg::*;

    if (Depth == 0) begin : g_bypass
        assign d_o = d_i;
    end else begin : g_chain
        logic [Depth-1:0] vld_q;
        lsu_result_t      dat_q [Depth];

        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= d_i.valid;
                for (int i = 1; i < Depth; i++) begin
                    vld_q[i] <= vld_q[i-1];
                end
            end
        end

        // payload shifts every cycle
        always_ff @(posedge clk_i) begin
            dat_q[0] <= d_i;
            for (int i = 1; i < Depth; i++) begin
                dat_q[i] <= dat_q[i-1];
            end
        end

        always_comb begin
            d_o       = dat_q[Depth-1];
            d_o.valid = vld_q[Depth-1];
        end
    end

endmodule

/* hdl/data_scratchpad.sv */
/* byte-enabled doubleword ram, contents undefined after reset
   read data is valid the cycle after rd_en_i */
module data_scratchpad #(
    parameter  int unsigned MEM_WORDS = 16,
    localparam int unsigned IDX_W     = $clog2(MEM_WORDS)
)(
    input  logic                     clk_i,
    input  logic                     rd_en_i,
    input  logic [IDX_W-1:0]         rd_index_i,
    output logic [lsu_pkg::XLEN-1:0] rd_data_o,
    input  logic                     wr_en_i,
    input  logic [IDX_W-1:0]         wr_index_i,
    input  logic [7:0]               wr_be_i,
    input  logic [lsu_pkg::XLEN-1:0] wr_data_i
);
    import lsu_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];

    // write lanes
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (wr_be_i[b]) begin
                    mem[wr_index_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
                end
            end
        end
    end

    // registered read, holds when idle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_index_i];
        end
    end

endmodule

/* hdl/lsu_addr_gen.sv */
/* combinational; byte enables of a misaligned access are truncated,
   such requests are trapped later in dispatch */
module lsu_addr_gen (
    input  lsu_pkg::fu_data_t fu_data_i,
    input  logic              lsu_valid_i,
    output lsu_pkg::lsu_req_t req_o
);
    import lsu_pkg::*;

    logic [XLEN-1:0] vaddr_xlen;
    logic [7:0]      size_mask;

    // two's complement add, same bits as signed imm + operand
    assign vaddr_xlen = fu_data_i.operand_a + fu_data_i.imm;

    // lane mask before the offset shift
    always_comb begin
        case (op_size(fu_data_i.op))
            2'd0:    size_mask = 8'h01;
            2'd1:    size_mask = 8'h03;
            2'd2:    size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    always_comb begin
        req_o.valid    = lsu_valid_i;
        req_o.vaddr    = vaddr_xlen[VLEN-1:0];
        // upper bits must be a sign extension of bit SV-1
        req_o.overflow = !((&vaddr_xlen[XLEN-1:SV-1]) || !(|vaddr_xlen[XLEN-1:SV-1]));
        req_o.data     = fu_data_i.operand_b;
        req_o.be       = size_mask << vaddr_xlen[2:0];
        req_o.fu       = fu_data_i.fu;
        req_o.op       = fu_data_i.op;
        req_o.trans_id = fu_data_i.trans_id;
    end

endmodule

/* hdl/lsu_bypass.sv */
/* two-entry request queue, ready only while empty
   at most one pop per cycle since only one unit owns the head */
module lsu_bypass (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              flush_i,
    input  lsu_pkg::lsu_req_t req_i,
    input  logic              pop_ld_i,
    input  logic              pop_st_i,
    output lsu_pkg::lsu_req_t lsu_ctrl_o,
    output logic              ready_o
);
    import lsu_pkg::*;

    lsu_req_t [1:0] mem_q;
    lsu_req_t [1:0] mem_n;
    logic           rd_ptr_q;
    logic           rd_ptr_n;
    logic           wr_ptr_q;
    logic           wr_ptr_n;
    logic [1:0]     cnt_q;
    logic [1:0]     cnt_n;
    logic           empty;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;

    always_comb begin
        mem_n    = mem_q;
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;
        // every request is written, a pop in the same cycle retires it
        if (req_i.valid) begin
            mem_n[wr_ptr_q] = req_i;
            wr_ptr_n        = ~wr_ptr_q;
            cnt_n           = cnt_n + 2'd1;
        end
        if (pop_ld_i || pop_st_i) begin
            mem_n[rd_ptr_q].valid = 1'b0;
            rd_ptr_n              = ~rd_ptr_q;
            cnt_n                 = cnt_n - 2'd1;
        end
        // flush drops everything queued
        if (flush_i) begin
            rd_ptr_n = 1'b0;
            wr_ptr_n = 1'b0;
            cnt_n    = 2'd0;
        end
    end

    // pass through while empty, else oldest entry
    assign lsu_ctrl_o = empty ? req_i : mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // entries are only read while counted
    always_ff @(posedge clk_i) begin
        mem_q <= mem_n;
    end

endmodule

/* hdl/lsu_dispatch.sv */
/* combinational exception check and unit steering
   access fault on overflow beats misalignment */
module lsu_dispatch (
    input  logic                en_translation_i,
    input  lsu_pkg::lsu_req_t   lsu_ctrl_i,
    output logic                ld_valid_o,
    output logic                st_valid_o,
    output lsu_pkg::exception_t ex_o
);
    import lsu_pkg::*;

    logic misaligned;
    logic is_load;

    assign is_load = (lsu_ctrl_i.fu == FU_LOAD);

    // ----------------------------------------
    // alignment by transfer size
    // ----------------------------------------
    always_comb begin
        case (op_size(lsu_ctrl_i.op))
            2'd3:    misaligned = (lsu_ctrl_i.vaddr[2:0] != 3'b000);
            2'd2:    misaligned = (lsu_ctrl_i.vaddr[1:0] != 2'b00);
            2'd1:    misaligned = lsu_ctrl_i.vaddr[0];
            // bytes never misalign
            default: misaligned = 1'b0;
        endcase
    end

    // ----------------------------------------
    // exception build
    // ----------------------------------------
    always_comb begin
        ex_o       = '0;
        ex_o.cause = is_load ? LD_ADDR_MISALIGNED : ST_ADDR_MISALIGNED;
        ex_o.tval  = {{(XLEN-VLEN){1'b0}}, lsu_ctrl_i.vaddr};
        if (lsu_ctrl_i.valid && (lsu_ctrl_i.fu != FU_NONE)) begin
            if (en_translation_i && lsu_ctrl_i.overflow) begin
                ex_o.cause = is_load ? LD_ACCESS_FAULT : ST_ACCESS_FAULT;
                ex_o.valid = 1'b1;
            end else if (misaligned) begin
                ex_o.valid = 1'b1;
            end
        end
    end

    // steer by functional unit
    assign ld_valid_o = lsu_ctrl_i.valid && is_load;
    assign st_valid_o = lsu_ctrl_i.valid && (lsu_ctrl_i.fu == FU_STORE);

endmodule

/* hdl/load_unit.sv */
/* one load in flight, result one cycle after acceptance
   stalls while the store buffer holds the same doubleword */
module load_unit #(
    parameter  int unsigned MEM_WORDS = 16,
    localparam int unsigned IDX_W     = $clog2(MEM_WORDS)
)(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  lsu_pkg::lsu_req_t         lsu_ctrl_i,
    input  lsu_pkg::exception_t       ex_i,
    input  logic                      sb_busy_i,
    input  logic [IDX_W-1:0]          sb_index_i,
    output logic                      pop_ld_o,
    output logic                      rd_en_o,
    output logic [IDX_W-1:0]          rd_index_o,
    input  logic [lsu_pkg::XLEN-1:0]  rd_data_i,
    output lsu_pkg::lsu_result_t      result_o
);
    import lsu_pkg::*;

    logic            stall;
    logic            accept;
    logic            q_valid;
    trans_id_t       q_trans_id;
    lsu_op_t         q_op;
    logic [2:0]      q_offset;
    exception_t      q_ex;
    logic [XLEN-1:0] shifted;

    // doubleword index, wraps over the scratchpad
    assign rd_index_o = lsu_ctrl_i.vaddr[IDX_W+2:3];

    // an excepting load never touches memory, so it need not wait
    assign stall    = sb_busy_i && !ex_i.valid && (sb_index_i == rd_index_o);
    assign accept   = valid_i && !stall;
    assign pop_ld_o = accept;
    assign rd_en_o  = accept && !ex_i.valid;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= accept;
        end
    end

    // opcode and offset travel with the read
    always_ff @(posedge clk_i) begin
        if (accept) begin
            q_trans_id <= lsu_ctrl_i.trans_id;
            q_op       <= lsu_ctrl_i.op;
            q_offset   <= lsu_ctrl_i.vaddr[2:0];
            q_ex       <= ex_i;
        end
    end

    // ----------------------------------------
    // align and extend
    // ----------------------------------------
    assign shifted = rd_data_i >> {q_offset, 3'b000};

    always_comb begin
        result_o.valid    = q_valid;
        result_o.trans_id = q_trans_id;
        result_o.ex       = q_ex;
        case (q_op)
            LB:      result_o.result = {{56{shifted[7]}}, shifted[7:0]};
            LBU:     result_o.result = {56'd0, shifted[7:0]};
            LH:      result_o.result = {{48{shifted[15]}}, shifted[15:0]};
            LHU:     result_o.result = {48'd0, shifted[15:0]};
            LW:      result_o.result = {{32{shifted[31]}}, shifted[31:0]};
            LWU:     result_o.result = {32'd0, shifted[31:0]};
            default: result_o.result = shifted;
        endcase
        // faulting load returns zero
        if (q_ex.valid) begin
            result_o.result = '0;
        end
    end

endmodule

/* hdl/store_unit.sv */
/* one-entry store buffer, drained every cycle
   stores are written without waiting for commit */
module store_unit #(
    parameter  int unsigned MEM_WORDS = 16,
    localparam int unsigned IDX_W     = $clog2(MEM_WORDS)
)(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      valid_i,
    input  lsu_pkg::lsu_req_t         lsu_ctrl_i,
    input  lsu_pkg::exception_t       ex_i,
    output logic                      pop_st_o,
    output logic                      sb_busy_o,
    output logic [IDX_W-1:0]          sb_index_o,
    output logic                      wr_en_o,
    output logic [IDX_W-1:0]          wr_index_o,
    output logic [7:0]                wr_be_o,
    output logic [lsu_pkg::XLEN-1:0]  wr_data_o,
    output lsu_pkg::lsu_result_t      result_o
);
    import lsu_pkg::*;

    logic       sb_valid_q;
    logic       res_valid_q;
    trans_id_t  res_trans_id_q;
    exception_t res_ex_q;

    // always accepted in the cycle it arrives
    assign pop_st_o = valid_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sb_valid_q  <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            // faulting stores skip the buffer
            sb_valid_q  <= valid_i && !ex_i.valid;
            res_valid_q <= valid_i;
        end
    end

    // buffer payload, data moved onto its byte lanes
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wr_index_o     <= lsu_ctrl_i.vaddr[IDX_W+2:3];
            wr_be_o        <= lsu_ctrl_i.be;
            wr_data_o      <= lsu_ctrl_i.data << {lsu_ctrl_i.vaddr[2:0], 3'b000};
            res_trans_id_q <= lsu_ctrl_i.trans_id;
            res_ex_q       <= ex_i;
        end
    end

    assign wr_en_o    = sb_valid_q;
    assign sb_busy_o  = sb_valid_q;
    assign sb_index_o = wr_index_o;

    always_comb begin
        result_o.valid    = res_valid_q;
        result_o.trans_id = res_trans_id_q;
        result_o.result   = '0;
        result_o.ex       = res_ex_q;
    end

endmodule

/* hdl/load_store_unit.sv */
/* load/store front end backed by a scratchpad, no mmu and no commit
   MEM_WORDS must be a power of two of at least 2, addresses wrap */
module load_store_unit #(
    parameter int unsigned MEM_WORDS          = 16,
    parameter int unsigned NR_LOAD_PIPE_REGS  = 1,
    parameter int unsigned NR_STORE_PIPE_REGS = 0
)(
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  logic                 en_translation_i,
    input  lsu_pkg::fu_data_t    fu_data_i,
    input  logic                 lsu_valid_i,
    output logic                 lsu_ready_o,
    output lsu_pkg::lsu_result_t load_o,
    output lsu_pkg::lsu_result_t store_o
);
    import lsu_pkg::*;

    // request path
    lsu_req_t   new_req;
    lsu_req_t   lsu_ctrl;
    logic       ld_valid;
    logic       st_valid;
    exception_t ex;
    logic       pop_ld;
    logic       pop_st;

    // store buffer hazard and memory ports
    logic                         sb_busy;
    logic [$clog2(MEM_WORDS)-1:0] sb_index;
    logic                         wr_en;
    logic [$clog2(MEM_WORDS)-1:0] wr_index;
    logic [7:0]                   wr_be;
    logic [XLEN-1:0]              wr_data;
    logic                         rd_en;
    logic [$clog2(MEM_WORDS)-1:0] rd_index;
    logic [XLEN-1:0]              rd_data;

    lsu_result_t ld_result;
    lsu_result_t st_result;

    // ----------------------------------------
    // address generation and queue
    // ----------------------------------------
    lsu_addr_gen i_addr_gen (
        .fu_data_i   ( fu_data_i   ),
        .lsu_valid_i ( lsu_valid_i ),
        .req_o       ( new_req     )
    );

    lsu_bypass i_bypass (
        .clk_i      ( clk_i       ),
        .rst_i      ( rst_i       ),
        .flush_i    ( flush_i     ),
        .req_i      ( new_req     ),
        .pop_ld_i   ( pop_ld      ),
        .pop_st_i   ( pop_st      ),
        .lsu_ctrl_o ( lsu_ctrl    ),
        .ready_o    ( lsu_ready_o )
    );

    lsu_dispatch i_dispatch (
        .en_translation_i ( en_translation_i ),
        .lsu_ctrl_i       ( lsu_ctrl         ),
        .ld_valid_o       ( ld_valid         ),
        .st_valid_o       ( st_valid         ),
        .ex_o             ( ex               )
    );

    // ----------------------------------------
    // units and memory
    // ----------------------------------------
    load_unit #(.MEM_WORDS(MEM_WORDS)) i_load_unit (
        .clk_i      ( clk_i     ),
        .rst_i      ( rst_i     ),
        .valid_i    ( ld_valid  ),
        .lsu_ctrl_i ( lsu_ctrl  ),
        .ex_i       ( ex        ),
        .sb_busy_i  ( sb_busy   ),
        .sb_index_i ( sb_index  ),
        .pop_ld_o   ( pop_ld    ),
        .rd_en_o    ( rd_en     ),
        .rd_index_o ( rd_index  ),
        .rd_data_i  ( rd_data   ),
        .result_o   ( ld_result )
    );

    store_unit #(.MEM_WORDS(MEM_WORDS)) i_store_unit (
        .clk_i      ( clk_i     ),
        .rst_i      ( rst_i     ),
        .valid_i    ( st_valid  ),
        .lsu_ctrl_i ( lsu_ctrl  ),
        .ex_i       ( ex        ),
        .pop_st_o   ( pop_st    ),
        .sb_busy_o  ( sb_busy   ),
        .sb_index_o ( sb_index  ),
        .wr_en_o    ( wr_en     ),
        .wr_index_o ( wr_index  ),
        .wr_be_o    ( wr_be     ),
        .wr_data_o  ( wr_data   ),
        .result_o   ( st_result )
    );

    data_scratchpad #(.MEM_WORDS(MEM_WORDS)) i_scratchpad (
        .clk_i      ( clk_i    ),
        .rd_en_i    ( rd_en    ),
        .rd_index_i ( rd_index ),
        .rd_data_o  ( rd_data  ),
        .wr_en_i    ( wr_en    ),
        .wr_index_i ( wr_index ),
        .wr_be_i    ( wr_be    ),
        .wr_data_i  ( wr_data  )
    );

    // output pipes, one per stream
    result_pipe #(.Depth(NR_LOAD_PIPE_REGS)) i_pipe_load (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .d_i   ( ld_result ),
        .d_o   ( load_o    )
    );

    result_pipe #(.Depth(NR_STORE_PIPE_REGS)) i_pipe_store (
        .clk_i ( clk_i     ),
        .rst_i ( rst_i     ),
        .d_i   ( st_result ),
        .d_o   ( store_o   )
    );

endmodule

/* test/tb_vectors.svh */
/* vector table of the lsu testbench, assumes a 16-word scratchpad
   exp_cause is ignored on rows with exp_ex low */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
    lsu_op_t     op;
    logic [63:0] base;
    logic [63:0] imm;
    logic        xlate;     // en_translation_i level for the row
    logic        b2b;       // strobe in the cycle right after the previous row
    logic        flush;     // flush_i together with the strobe
    logic        exp_ex;
    exc_cause_t  exp_cause;
} vec_t;

localparam int NUM_VECS = 31;

// op, base, imm, xlate, b2b, flush, exp_ex, exp_cause
localparam vec_t VECS [NUM_VECS] = '{
    // fill words 0 to 3
    '{SD,  64'h00, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{SD,  64'h08, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{SD,  64'h10, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{SD,  64'h18, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    // every load size, signed and unsigned
    '{LD,  64'h00, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LB,  64'h00, 64'h3, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LBU, 64'h10, 64'hffff_ffff_ffff_fffd, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LH,  64'h0a, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LHU, 64'h0e, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LW,  64'h14, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LWU, 64'h10, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    // narrow stores, read back whole
    '{SB,  64'h01, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{SH,  64'h0c, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{SW,  64'h18, 64'h4, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h00, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h08, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h18, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    // misaligned, then proof that word 3 kept its data
    '{LW,  64'h22, 64'h0, 1'b0, 1'b0, 1'b0, 1'b1, LD_ADDR_MISALIGNED},
    '{SW,  64'h1a, 64'h0, 1'b0, 1'b0, 1'b0, 1'b1, ST_ADDR_MISALIGNED},
    '{LD,  64'h18, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    // bit 38 set without sign extension
    '{LD,  64'h40_0000_0010, 64'h0, 1'b1, 1'b0, 1'b0, 1'b1, LD_ACCESS_FAULT},
    '{SD,  64'h40_0000_0010, 64'h0, 1'b1, 1'b0, 1'b0, 1'b1, ST_ACCESS_FAULT},
    '{SD,  64'h40_0000_0010, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h10, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    // store then dependent load one cycle later
    '{SD,  64'h18, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h18, 64'h0, 1'b0, 1'b1, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{SH,  64'h08, 64'h6, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LHU, 64'h0e, 64'h0, 1'b0, 1'b1, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    // stalled load dropped by flush, store still lands
    '{SD,  64'h00, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h00, 64'h0, 1'b0, 1'b1, 1'b1, 1'b0, LD_ADDR_MISALIGNED},
    '{LD,  64'h00, 64'h0, 1'b0, 1'b0, 1'b0, 1'b0, LD_ADDR_MISALIGNED}
};

`endif

/* test/tb_load_store_unit.sv */
/* table driven test of the lsu with 16 words and two-stage result pipes
   expected loads come from a byte shadow of the scratchpad */
module tb_load_store_unit;
    import lsu_pkg::*;

    `include "tb_vectors.svh"

    localparam int unsigned MEM_WORDS      = 16;
    localparam int          TIMEOUT_CYCLES = 20 * NUM_VECS;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        en_translation;
    fu_data_t    fu_data;
    logic        lsu_valid;
    logic        lsu_ready;
    lsu_result_t load_res;
    lsu_result_t store_res;

    // expected results in issue order, each with its table row
    lsu_result_t load_q[$];
    lsu_result_t store_q[$];
    int          load_row_q[$];
    int          store_row_q[$];

    logic [7:0] shadow [MEM_WORDS*8];
    int         seed   = 32'h8f8a;
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    load_store_unit #(
        .MEM_WORDS          ( MEM_WORDS ),
        .NR_LOAD_PIPE_REGS  ( 2         ),
        .NR_STORE_PIPE_REGS ( 2         )
    ) i_dut (
        .clk_i            ( clk            ),
        .rst_i            ( rst            ),
        .flush_i          ( flush          ),
        .en_translation_i ( en_translation ),
        .fu_data_i        ( fu_data        ),
        .lsu_valid_i      ( lsu_valid      ),
        .lsu_ready_o      ( lsu_ready      ),
        .load_o           ( load_res       ),
        .store_o          ( store_res      )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic int size_bytes(lsu_op_t op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic logic is_load_op(lsu_op_t op);
        case (op)
            LB, LBU, LH, LHU, LW, LWU, LD: return 1'b1;
            default:                       return 1'b0;
        endcase
    endfunction

    // bytes above the size stay zero, signed ops extend
    function automatic logic [63:0] load_value(logic [63:0] addr, lsu_op_t op);
        logic [63:0] raw;
        logic [6:0]  idx;
        raw = '0;
        for (int k = 0; k < size_bytes(op); k++) begin
            idx             = addr[6:0] + 7'(k);
            raw[k*8 +: 8]   = shadow[idx];
        end
        case (op)
            LB:      return {{56{raw[7]}}, raw[7:0]};
            LH:      return {{48{raw[15]}}, raw[15:0]};
            LW:      return {{32{raw[31]}}, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    // index wraps with the low address bits, like the scratchpad
    task automatic shadow_store(logic [63:0] addr, lsu_op_t op, logic [63:0] data);
        logic [6:0] idx;
        for (int k = 0; k < size_bytes(op); k++) begin
            idx         = addr[6:0] + 7'(k);
            shadow[idx] = data[k*8 +: 8];
        end
    endtask

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_result(lsu_result_t got, lsu_result_t exp, string what);
        logic bad;
        bad = (got.valid !== exp.valid);
        if (exp.valid) begin
            bad = bad || (got.trans_id !== exp.trans_id) || (got.result !== exp.result);
            bad = bad || (got.ex.valid !== exp.ex.valid);
            // cause and tval only count on an exception
            if (exp.ex.valid) begin
                bad = bad || (got.ex.cause !== exp.ex.cause) || (got.ex.tval !== exp.ex.tval);
            end
        end
        checks++;
        if (bad) begin
            errors++;
            $display("[FAIL] %0t: %s got id %0d data %h ex %b cause %0d tval %h", $time, what,
                     got.trans_id, got.result, got.ex.valid, got.ex.cause, got.ex.tval);
            $display("[FAIL] %0t: %s want id %0d data %h ex %b cause %0d tval %h", $time, what,
                     exp.trans_id, exp.result, exp.ex.valid, exp.ex.cause, exp.ex.tval);
        end else begin
            $display("%s ok", what);
        end
    endtask

    task automatic check_ready(logic got, logic exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ----------------------------------------
    // monitors, sampled away from the rising edge
    // ----------------------------------------
    always @(negedge clk) begin : load_monitor
        int row;
        if (!rst && load_res.valid === 1'b1) begin
            if (load_q.size() == 0) begin
                errors++;
                $display("load result with trans_id %0d at %0t was never issued",
                         load_res.trans_id, $time);
            end else begin
                row = load_row_q.pop_front();
                check_result(load_res, load_q.pop_front(), $sformatf("row %0d load", row));
            end
        end
    end

    always @(negedge clk) begin : store_monitor
        int row;
        if (!rst && store_res.valid === 1'b1) begin
            if (store_q.size() == 0) begin
                errors++;
                $display("store result with trans_id %0d at %0t was never issued",
                         store_res.trans_id, $time);
            end else begin
                row = store_row_q.pop_front();
                check_result(store_res, store_q.pop_front(), $sformatf("row %0d store", row));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // driver
    // ----------------------------------------
    initial begin : driver
        vec_t        vec;
        logic [63:0] addr;
        logic [63:0] data;
        lsu_result_t exp;

        rst            = 1'b1;
        flush          = 1'b0;
        en_translation = 1'b0;
        lsu_valid      = 1'b0;
        fu_data        = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_ready(lsu_ready, 1'b1, "lsu_ready after reset");
        check_result(load_res, '0, "load stream idle after reset");
        check_result(store_res, '0, "store stream idle after reset");

        for (int i = 0; i < NUM_VECS; i++) begin
            vec = VECS[i];
            // idle cycle unless the row follows straight on
            if (!vec.b2b) begin
                @(negedge clk);
            end
            while (!lsu_ready) begin
                @(negedge clk);
            end
            addr = vec.base + vec.imm;
            data = is_load_op(vec.op) ? 64'd0 : {$random(seed), $random(seed)};

            exp          = '0;
            exp.valid    = 1'b1;
            exp.trans_id = trans_id_t'(i);
            exp.ex.valid = vec.exp_ex;
            exp.ex.cause = vec.exp_cause;
            exp.ex.tval  = {25'd0, addr[38:0]};
            if (is_load_op(vec.op)) begin
                if (!vec.exp_ex) begin
                    exp.result = load_value(addr, vec.op);
                end
                // a flushed load leaves nothing behind
                if (!vec.flush) begin
                    load_q.push_back(exp);
                    load_row_q.push_back(i);
                end
            end else begin
                if (!vec.exp_ex) begin
                    shadow_store(addr, vec.op, data);
                end
                store_q.push_back(exp);
                store_row_q.push_back(i);
            end

            fu_data.fu        = is_load_op(vec.op) ? FU_LOAD : FU_STORE;
            fu_data.op        = vec.op;
            fu_data.operand_a = vec.base;
            fu_data.operand_b = data;
            fu_data.imm       = vec.imm;
            fu_data.trans_id  = trans_id_t'(i);
            en_translation    = vec.xlate;
            flush             = vec.flush;
            lsu_valid         = 1'b1;
            @(negedge clk);
            lsu_valid = 1'b0;
            flush     = 1'b0;

            // stalled follower sits in the queue for a cycle unless flushed
            if (vec.b2b) begin
                check_ready(lsu_ready, vec.flush, $sformatf("lsu_ready after row %0d", i));
                if (vec.flush) begin
                    $display("row %0d flushed, no result expected", i);
                end
            end
        end

        while (load_q.size() != 0 || store_q.size() != 0) begin
            @(negedge clk);
        end
        // quiet window to catch stray results
        repeat (6) @(negedge clk);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+test
hdl/lsu_pkg.sv
hdl/result_pipe.sv
hdl/data_scratchpad.sv
hdl/lsu_addr_gen.sv
hdl/lsu_bypass.sv
hdl/lsu_dispatch.sv
hdl/load_unit.sv
hdl/store_unit.sv
hdl/load_store_unit.sv
test/tb_load_store_unit.sv

/* Makefile */
# verilator flow for the load/store unit testbench

SIM := obj_dir/Vtb_load_store_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -Wno-fatal --top-module tb_load_store_unit -f all.f

run: compile
	./$(SIM) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
